//--- flist.f
source/lcdPkg.sv
source/lcdBusIf.sv
source/lcdWaitTimer.sv
source/lcdBusWriter.sv
source/lcdSequencer.sv
source/lcdDisplayTop.sv
tests/lcdDisplay_props.sv
tests/lcdDisplayTb.sv

//--- Makefile
# Verilator build and run for the LCD display testbench

SRCS := $(shell grep -v '^+' flist.f)
BIN  := obj_dir/VlcdDisplayTb

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): flist.f $(SRCS)
	verilator --binary --timing --assert --top-module lcdDisplayTb -f flist.f

# The log decides pass or fail
run: $(BIN)
	./$(BIN) | tee sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tests/lcdDisplayTb.sv
// ==============================
// LCD display testbench with text
// frame table, pin monitor, watchdog
// ==============================
`default_nettype none

module lcdDisplayTb;

	localparam int E_PULSE_CYCLES = 4;
	localparam int SETTLE_CYCLES  = 8;
	localparam int FRAMES         = 4;
	localparam int INIT_WRITES    = 5;
	localparam int FRAME_WRITES   = 34;	// Two addresses and 32 characters
	localparam int WATCHDOG_CYCLES =
		(FRAMES + 1) * FRAME_WRITES * (E_PULSE_CYCLES + SETTLE_CYCLES + 6) * 2;

	logic         CLOCK;
	logic         RST_n;
	logic [127:0] lineText1;
	logic [127:0] lineText2;
	logic         initDone;
	logic         lcdRs;
	logic         lcdRw;
	logic         lcdEn;
	logic [7:0]   lcdData;

	// Text frames with the first character in the top byte
	logic [127:0] textTab1 [FRAMES] = '{
		"Hello, LCD 16x2!",
		{16{8'h20}},	// All blanks
		{8'hFF, "ABCDEFGHIJKLMN", 8'h00},
		"Frame number  4 "
	};
	logic [127:0] textTab2 [FRAMES] = '{
		"Line two text   ",
		"    centered    ",
		{8'h00, "0123456789abcd", 8'hFF},
		{16{8'h20}}
	};
	logic [7:0] initBytes [INIT_WRITES] = '{8'h38, 8'h08, 8'h01, 8'h06, 8'h0C};

	logic       capRs [$];	// One entry per E falling edge
	logic [7:0] capData [$];
	int   capCount   = 0;
	int   initPulses = 0;
	int   highCycles = 0;
	int   lowCycles  = 0;
	int   pulseCount = 0;
	logic enPrev     = 1'b0;
	logic initPrev   = 1'b0;

	lcdDisplayTop #(
		.E_PULSE_CYCLES(E_PULSE_CYCLES),
		.SETTLE_CYCLES (SETTLE_CYCLES)
	) dut0 (
		.CLOCK    (CLOCK),
		.RST_n    (RST_n),
		.lineText1(lineText1),
		.lineText2(lineText2),
		.initDone (initDone),
		.lcdRs    (lcdRs),
		.lcdRw    (lcdRw),
		.lcdEn    (lcdEn),
		.lcdData  (lcdData)
	);

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("Fail %s expected %0h got %0h", name, expected, actual);
			$display("Testbench failed");
			$fatal(1);
		end
	endtask

	task automatic checkWrite(input int idx, input logic rs, input logic [7:0] data);
		checkValue($sformatf("lcdRs write %0d", idx), 32'(rs), 32'(capRs[idx]));
		checkValue($sformatf("lcdData write %0d", idx), 32'(data), 32'(capData[idx]));
	endtask

	// Address, 16 chars, address, 16 chars
	task automatic checkFrame(input int base, input logic [127:0] line1,
		input logic [127:0] line2);
		checkWrite(base, 1'b0, 8'h80);
		for (int j = 0; j < 16; j++)
			checkWrite(base + 1 + j, 1'b1, line1[127 - 8 * j -: 8]);
		checkWrite(base + 17, 1'b0, 8'hC0);
		for (int j = 0; j < 16; j++)
			checkWrite(base + 18 + j, 1'b1, line2[127 - 8 * j -: 8]);
	endtask

	initial begin
		CLOCK = 1'b0;
		forever #5 CLOCK = ~CLOCK;
	end

	// Each falling edge of E is one write
	always @(negedge lcdEn) begin
		if (RST_n === 1'b1) begin
			if (capCount == INIT_WRITES)
				checkValue("initDone pulses before line 1", 32'd1, 32'(initPulses));
			capRs.push_back(lcdRs);
			capData.push_back(lcdData);
			capCount++;
		end
	end

	// E pulse widths, RW and initDone checked on every cycle
	always @(posedge CLOCK) begin
		if (RST_n === 1'b1) begin
			checkValue("lcdRw", 32'd0, 32'(lcdRw));
			if (lcdEn) begin
				if (!enPrev && pulseCount > 0)
					checkValue("lcdEn low gap long enough", 32'd1,
						32'(lowCycles >= SETTLE_CYCLES + 1));
				highCycles = enPrev ? highCycles + 1 : 1;
			end else begin
				if (enPrev) begin
					checkValue("lcdEn high cycles", E_PULSE_CYCLES, highCycles);
					pulseCount++;
				end
				lowCycles = enPrev ? 1 : lowCycles + 1;
			end
			enPrev = lcdEn;
			if (initDone) begin
				checkValue("initDone previous cycle", 32'd0, 32'(initPrev));
				checkValue("writes before initDone", INIT_WRITES, capCount);
				initPulses++;
			end
			initPrev = initDone;
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge CLOCK);
		$display("Display stopped writing before all frames were checked");
		$display("Testbench failed");
		$fatal(1);
	end

	initial begin
		int base;
		RST_n     = 1'b0;
		lineText1 = textTab1[0];
		lineText2 = textTab2[0];
		repeat (10) @(posedge CLOCK);
		RST_n <= 1'b1;

		@(negedge CLOCK);
		checkValue("lcdEn", 32'd0, 32'(lcdEn));
		checkValue("initDone", 32'd0, 32'(initDone));
		checkValue("lcdRw", 32'd0, 32'(lcdRw));
		checkValue("lcdData", 32'd0, 32'(lcdData));

		wait (capCount >= INIT_WRITES);
		for (int i = 0; i < INIT_WRITES; i++)
			checkWrite(i, 1'b0, initBytes[i]);

		for (int k = 0; k < FRAMES; k++) begin
			base = INIT_WRITES + k * FRAME_WRITES;
			wait (capCount >= base + 1);	// Line 1 address written with entry k latched
			wait (capCount >= base + 8);
			if (k < FRAMES - 1) begin
				@(posedge CLOCK);
				lineText1 <= textTab1[k + 1];	// Mid-frame text change
				lineText2 <= textTab2[k + 1];
			end
			wait (capCount >= base + FRAME_WRITES);
			checkFrame(base, textTab1[k], textTab2[k]);
		end

		checkValue("initDone pulses", 32'd1, 32'(initPulses));
		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- tests/lcdDisplay_props.sv
// ==============================
// Bus writer pin and handshake
// assertions, bound to the writer
// ==============================
`default_nettype none

module lcdBusWriterProps (
	input wire logic       CLOCK,
	input wire logic       RST_n,
	input wire logic       lcdRs,
	input wire logic       lcdEn,
	input wire logic [7:0] lcdData,
	input wire logic       done,
	input wire logic       cmdCall,
	input wire logic       dataCall
);

	// Pins frozen across the whole E pulse
	rsDataStable: assert property (@(posedge CLOCK) disable iff (!RST_n)
		(lcdEn && $past(lcdEn)) |-> ($stable(lcdRs) && $stable(lcdData)))
		else $error("RS or data changed while E was high");

	doneNotInPulse: assert property (@(posedge CLOCK) disable iff (!RST_n)
		!(done && lcdEn))
		else $error("done was high while E was high");

	oneCallAtATime: assert property (@(posedge CLOCK) disable iff (!RST_n)
		!(cmdCall && dataCall))
		else $error("cmdCall and dataCall were high together");

endmodule

bind lcdBusWriter lcdBusWriterProps props0 (
	.CLOCK   (CLOCK),
	.RST_n   (RST_n),
	.lcdRs   (lcdRs),
	.lcdEn   (lcdEn),
	.lcdData (lcdData),
	.done    (bus.done),
	.cmdCall (bus.cmdCall),
	.dataCall(bus.dataCall)
);

`default_nettype wire

//--- source/lcdDisplayTop.sv
// ==============================
// 16x2 LCD display subsystem top
// ==============================
`default_nettype none

module lcdDisplayTop import lcdPkg::*; #(
	parameter int E_PULSE_CYCLES = 4,	// E high time in clocks
	parameter int SETTLE_CYCLES  = 8	// Wait after each write
) (
	input  wire logic                 CLOCK,
	input  wire logic                 RST_n,
	input  wire logic [LINE_BITS-1:0] lineText1,
	input  wire logic [LINE_BITS-1:0] lineText2,
	output logic                      initDone,
	output logic                      lcdRs,
	output logic                      lcdRw,
	output logic                      lcdEn,
	output logic [7:0]                lcdData
);

	lcdBusIf bus0 ();

	lcdSequencer seq0 (
		.CLOCK    (CLOCK),
		.RST_n    (RST_n),
		.lineText1(lineText1),
		.lineText2(lineText2),
		.initDone (initDone),
		.bus      (bus0.sequencer)
	);

	lcdBusWriter #(
		.E_PULSE_CYCLES(E_PULSE_CYCLES),
		.SETTLE_CYCLES (SETTLE_CYCLES)
	) writer0 (
		.CLOCK  (CLOCK),
		.RST_n  (RST_n),
		.bus    (bus0.writer),
		.lcdRs  (lcdRs),
		.lcdRw  (lcdRw),
		.lcdEn  (lcdEn),
		.lcdData(lcdData)
	);

endmodule

`default_nettype wire

//--- source/lcdSequencer.sv
// ==============================
// Init and refresh sequencer with
// frame buffer for both text lines
// ==============================
`default_nettype none

module lcdSequencer import lcdPkg::*; (
	input  wire logic                 CLOCK,
	input  wire logic                 RST_n,
	input  wire logic [LINE_BITS-1:0] lineText1,
	input  wire logic [LINE_BITS-1:0] lineText2,
	output logic                      initDone,
	lcdBusIf.sequencer                bus
);

	seqState_t state;
	logic [2:0] initIdx;
	logic [3:0] charIdx;
	logic callActive;
	logic callIsData;
	logic raiseCall;
	logic lastChar;
	logic [7:0] byteReg;
	logic [7:0] nextByte;
	logic nextIsData;
	logic [LINE_BITS-1:0] frameLine1;
	logic [LINE_BITS-1:0] frameLine2;

	assign raiseCall = (state != S_INIT_DONE) && !callActive;
	assign lastChar  = charIdx == 4'(LINE_CHARS - 1);

	// Byte for the step the FSM is on
	always_comb begin
		nextByte   = 8'h00;
		nextIsData = 1'b0;
		case (state)
			S_INIT:  nextByte = initCmd(initIdx);
			S_ADDR1: nextByte = CMD_LINE1_ADDR;
			S_LINE1: begin
				nextByte   = frameLine1[LINE_BITS - 1 - 8 * charIdx -: 8];
				nextIsData = 1'b1;
			end
			S_ADDR2: nextByte = CMD_LINE2_ADDR;
			S_LINE2: begin
				nextByte   = frameLine2[LINE_BITS - 1 - 8 * charIdx -: 8];
				nextIsData = 1'b1;
			end
			default: nextByte = 8'h00;
		endcase
	end

	always_ff @(posedge CLOCK or negedge RST_n) begin
		if (!RST_n) begin
			state      <= S_INIT;
			initIdx    <= 3'd0;
			charIdx    <= 4'd0;
			callActive <= 1'b0;
			callIsData <= 1'b0;
			initDone   <= 1'b0;
		end else begin
			initDone <= 1'b0;
			if (state == S_INIT_DONE) begin
				initDone <= 1'b1;	// Single pulse, then start refreshing
				state    <= S_ADDR1;
			end else if (bus.done) begin
				callActive <= 1'b0;	// Call drops for one cycle
				case (state)
					S_INIT: begin
						if (initIdx == 3'(INIT_CMDS - 1))
							state <= S_INIT_DONE;
						else
							initIdx <= initIdx + 3'd1;
					end
					S_ADDR1: state <= S_LINE1;
					S_LINE1: begin
						charIdx <= charIdx + 4'd1;	// Wraps to 0 after last char
						if (lastChar)
							state <= S_ADDR2;
					end
					S_ADDR2: state <= S_LINE2;
					S_LINE2: begin
						charIdx <= charIdx + 4'd1;
						if (lastChar)
							state <= S_ADDR1;	// Next frame
					end
					default: state <= S_INIT;
				endcase
			end else if (raiseCall) begin
				callActive <= 1'b1;
				callIsData <= nextIsData;
			end
		end
	end

	// Byte and frame text only change while the call is low
	always_ff @(posedge CLOCK) begin
		if (raiseCall)
			byteReg <= nextByte;
		if (raiseCall && state == S_ADDR1) begin
			frameLine1 <= lineText1;	// Snapshot so a frame never tears
			frameLine2 <= lineText2;
		end
	end

	assign bus.cmdCall  = callActive && !callIsData;
	assign bus.dataCall = callActive && callIsData;
	assign bus.byteOut  = byteReg;

endmodule

`default_nettype wire

//--- source/lcdBusWriter.sv
// ==============================
// HD44780 pin driver, one byte
// per call with timed E strobe
// ==============================
`default_nettype none

module lcdBusWriter import lcdPkg::*; #(
	parameter int E_PULSE_CYCLES = 4,
	parameter int SETTLE_CYCLES  = 8
) (
	input  wire logic CLOCK,
	input  wire logic RST_n,
	lcdBusIf.writer   bus,
	output logic       lcdRs,
	output logic       lcdRw,
	output logic       lcdEn,
	output logic [7:0] lcdData
);

	localparam int TIMER_BITS = 8;

	wrState_t state;
	wrState_t nextState;
	logic timerLoad;
	logic [TIMER_BITS-1:0] timerValue;
	logic timerExpired;

	lcdWaitTimer #(
		.TIMER_BITS(TIMER_BITS)
	) timer0 (
		.CLOCK    (CLOCK),
		.RST_n    (RST_n),
		.load     (timerLoad),
		.loadValue(timerValue),
		.expired  (timerExpired)
	);

	always_comb begin
		nextState = state;
		case (state)
			W_IDLE:  if (bus.cmdCall || bus.dataCall) nextState = W_SETUP;
			W_SETUP: nextState = W_PULSE;
			W_PULSE: if (timerExpired) nextState = W_HOLD;
			W_HOLD:  if (timerExpired) nextState = W_DONE;
			W_DONE:  nextState = W_IDLE;
			default: nextState = W_IDLE;
		endcase
	end

	// Load is one short since the loaded value counts as a cycle
	assign timerLoad  = (state == W_SETUP) || (state == W_PULSE && timerExpired);
	assign timerValue = (state == W_SETUP) ? TIMER_BITS'(E_PULSE_CYCLES - 1)
		: TIMER_BITS'(SETTLE_CYCLES - 1);

	always_ff @(posedge CLOCK or negedge RST_n) begin
		if (!RST_n) begin
			state    <= W_IDLE;
			lcdEn    <= 1'b0;
			lcdRw    <= 1'b0;
			lcdRs    <= 1'b0;
			lcdData  <= 8'h00;
			bus.done <= 1'b0;
		end else begin
			state    <= nextState;
			lcdEn    <= nextState == W_PULSE;
			lcdRw    <= 1'b0;	// Write only
			bus.done <= nextState == W_DONE;
			if (state == W_IDLE && nextState == W_SETUP) begin
				lcdRs   <= bus.dataCall;	// Valid from W_SETUP on
				lcdData <= bus.byteOut;
			end
		end
	end

endmodule

`default_nettype wire

//--- source/lcdWaitTimer.sv
// ==============================
// Loadable down-counter for the
// enable and settle intervals
// ==============================
`default_nettype none

module lcdWaitTimer #(
	parameter int TIMER_BITS = 8
) (
	input  wire logic                  CLOCK,
	input  wire logic                  RST_n,
	input  wire logic                  load,
	input  wire logic [TIMER_BITS-1:0] loadValue,
	output logic                       expired
);

	logic [TIMER_BITS-1:0] count;

	always_ff @(posedge CLOCK or negedge RST_n) begin
		if (!RST_n) begin
			count <= '0;
		end else if (load) begin
			count <= loadValue;
		end else if (count != '0) begin
			count <= count - 1'b1;	// Stops at zero
		end
	end

	// Stays high at zero until reloaded
	assign expired = count == '0;

endmodule

`default_nettype wire

//--- source/lcdBusIf.sv
// ==============================
// Byte request channel between
// sequencer and bus writer
// ==============================
`default_nettype none

interface lcdBusIf;

	logic       cmdCall;	// Byte is a command, RS low
	logic       dataCall;	// Byte is a character, RS high
	logic [7:0] byteOut;
	logic       done;	// One-cycle completion pulse

	modport sequencer (
		output cmdCall,
		output dataCall,
		output byteOut,
		input  done
	);

	modport writer (
		input  cmdCall,
		input  dataCall,
		input  byteOut,
		output done
	);

endinterface

`default_nettype wire

//--- source/lcdPkg.sv
// ==============================
// LCD command bytes, FSM state types,
// line geometry and init list lookup
// ==============================
`default_nettype none

package lcdPkg;

	localparam int LINE_CHARS = 16;	// Characters per display line
	localparam int LINE_BITS  = 128;	// First character in the top byte
	localparam int INIT_CMDS  = 5;

	typedef enum logic [7:0] {
		CMD_CLEAR      = 8'h01,
		CMD_ENTRY      = 8'h06,	// Increment, no shift
		CMD_DISP_OFF   = 8'h08,
		CMD_DISP_ON    = 8'h0C,	// Cursor and blink off
		CMD_FUNC_SET   = 8'h38,	// 8-bit bus, 2 lines, 5x8 font
		CMD_LINE1_ADDR = 8'h80,
		CMD_LINE2_ADDR = 8'hC0
	} lcdCmd_t;

	typedef enum logic [2:0] {
		S_INIT,
		S_INIT_DONE,
		S_ADDR1,
		S_LINE1,
		S_ADDR2,
		S_LINE2
	} seqState_t;

	typedef enum logic [2:0] {
		W_IDLE,
		W_SETUP,
		W_PULSE,
		W_HOLD,
		W_DONE
	} wrState_t;

	// Power-up command order
	function automatic lcdCmd_t initCmd(input logic [2:0] idx);
		case (idx)
			3'd0: return CMD_FUNC_SET;
			3'd1: return CMD_DISP_OFF;
			3'd2: return CMD_CLEAR;
			3'd3: return CMD_ENTRY;
			default: return CMD_DISP_ON;
		endcase
	endfunction

endpackage

`default_nettype wire
